//--- Makefile
# Verilator flow for the clearing PRNG: lint, simulate, clean

VERILATOR  ?= verilator
FILE_LIST  := clearing_prng.f
TB_TOP     := tb_clearing_prng
RTL_TOP    := clearing_prng
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
SIM_LOG    := sim.log
FAIL_MSG   := Errors found

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(SIM_LOG) 2>&1; status=$$?; cat $(SIM_LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(SIM_LOG); then \
	  echo "Simulation failed, see $(SIM_LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)

//--- clearing_prng.f
+incdir+logic
logic/prng_pkg.sv
logic/prng_reseed_collector.sv
logic/prng_lfsr_core.sv
logic/clearing_prng.sv
dv/prng_clk_gen.sv
dv/prng_checker.sv
dv/tb_clearing_prng.sv

//--- dv/clearing_prng_stim.txt
# R <entropy high word> <entropy low word> <max ack gap in cycles>
# D <request cycles> <check first share0, 1 or 0> <expected first share0>
# X <entropy high word> <entropy low word> <request cycles> <expected share0 after reseed>
# I <idle cycles>
D 1 1 882BCB25D05AC79D
D 12 0 0
I 6
D 5 0 0
R 00000000 00000001 4
D 1 1 BBBBBBBBBBBBBBBF
D 20 0 0
R 80000000 00000000 6
D 8 1 BBB6BBBBBBBBBBBB
X FFFFFFFF FFFFFFFF 10 4444444444444444
D 16 0 0
R 3C5A96E1 0F1E2D3B 3
D 30 0 0
X 00000000 00000001 6 BBBBBBBBBBBBBBBF
D 4 0 0
R 12345678 9ABCDEF0 0
D 1 0 0
I 4

//--- dv/prng_checker.sv
// Scoreboard for the clearing PRNG; models the LFSR, compares DUT ports and prints per test
`timescale 1ns/1ps
`include "prng_settings.svh"

module prng_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    data_req_i,
  input  logic                    data_ack_i,
  input  prng_pkg::prng_word_t    data0_i,
  input  prng_pkg::prng_word_t    data1_i,
  input  logic                    reseed_req_i,
  input  logic                    reseed_ack_i,
  input  logic                    entropy_req_i,
  input  logic                    entropy_ack_i,
  input  prng_pkg::entropy_word_t entropy_i,
  // Expected first share 0 from the stimulus file
  input  logic                    exp_en_i,
  input  prng_pkg::prng_word_t    exp_data0_i,
  // Test bookkeeping from the testbench top
  input  int                      test_id_i,
  input  logic [7:0]              test_kind_i,
  input  logic                    test_end_i,
  input  logic                    report_i,
  output int                      error_count_o
);
  import prng_pkg::*;

  // PRINCE S-box
  localparam logic [3:0] sbox_table [16] = '{
    4'hB, 4'hF, 4'h3, 4'h2, 4'hA, 4'hC, 4'h9, 4'h1,
    4'h6, 4'h7, 4'h8, 4'h0, 4'hE, 4'h5, 4'hD, 4'h4
  };

  prng_word_t    model_q;
  prng_word_t    exp0;
  entropy_word_t hi_word;
  int            words;
  logic          exp_ack;
  logic          seed_done;
  int            test_checks  = 0;
  int            test_errors  = 0;
  int            total_checks = 0;
  int            total_errors = 0;
  int            tests_run    = 0;

  assign error_count_o = total_errors;

  // Walk the source index in steps of mul, starting at add
  function automatic prng_word_t permute_bits(input prng_word_t x, input int mul, input int add);
    prng_word_t y;
    int         src;
    src = add % `PRNG_WIDTH;
    for (int i = 0; i < `PRNG_WIDTH; i++) begin
      y[i] = x[src];
      src  = (src + mul) % `PRNG_WIDTH;
    end
    return y;
  endfunction

  // State permutation, then one S-box per nibble
  function automatic prng_word_t expected_share0(input prng_word_t state);
    prng_word_t p;
    prng_word_t y;
    p = permute_bits(state, `PRNG_STATE_PERM_MUL, 0);
    for (int n = 0; n < `PRNG_WIDTH / 4; n++) begin
      y[4*n +: 4] = sbox_table[p[4*n +: 4]];
    end
    return y;
  endfunction

  function automatic prng_word_t share1_of(input prng_word_t share0);
    return permute_bits(share0, `PRNG_SHARE_PERM_MUL, `PRNG_SHARE_PERM_ADD);
  endfunction

  // Galois step with feedback only when the dropped bit is one
  function automatic prng_word_t lfsr_next(input prng_word_t state);
    if (state[0]) begin
      return (state >> 1) ^ `PRNG_LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  task automatic check_word(input string name, input prng_word_t got, input prng_word_t exp);
    test_checks++;
    total_checks++;
    if (got !== exp) begin
      test_errors++;
      total_errors++;
      $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    test_checks++;
    total_checks++;
    if (got !== exp) begin
      test_errors++;
      total_errors++;
      $display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Sample on the falling edge where all DUT outputs have settled
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      model_q = `PRNG_DEFAULT_SEED;
      words   = 0;
    end else begin
      exp_ack   = data_req_i && !reseed_req_i;
      seed_done = 1'b0;
      check_bit("data_ack_o", data_ack_i, exp_ack);
      check_bit("entropy_req_o", entropy_req_i, reseed_req_i);
      // Outputs must also hold still while a reseed is pending
      if (exp_ack || reseed_req_i) begin
        exp0 = expected_share0(model_q);
        check_word("data0_o", data0_i, exp0);
        check_word("data1_o", data1_i, share1_of(exp0));
        check_word("data1_o from data0_o", data1_i, share1_of(data0_i));
      end
      if (exp_en_i && exp_ack) begin
        check_word("data0_o first output", data0_i, exp_data0_i);
      end
      // Two accepted words make one seed, high word first
      if (reseed_req_i && entropy_ack_i) begin
        if (words == 0) begin
          hi_word = entropy_i;
          words   = 1;
          check_bit("reseed_ack_o", reseed_ack_i, 1'b0);
        end else begin
          check_bit("reseed_ack_o", reseed_ack_i, 1'b1);
          model_q   = {hi_word, entropy_i};
          words     = 0;
          seed_done = 1'b1;
        end
      end else begin
        check_bit("reseed_ack_o", reseed_ack_i, 1'b0);
      end
      if (!seed_done && exp_ack) begin
        model_q = lfsr_next(model_q);
      end
      if (test_end_i) begin
        tests_run++;
        $display("Test %0d (%c): %0d checks, %0d errors, %s", test_id_i, test_kind_i,
                 test_checks, test_errors, (test_errors == 0) ? "PASS" : "FAIL");
        test_checks = 0;
        test_errors = 0;
      end
      if (report_i) begin
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 tests_run, total_checks, total_errors);
      end
    end
  end

endmodule

//--- dv/prng_clk_gen.sv
// Clock and reset source for the clearing PRNG testbench; 40 ns clock, reset held for 5 cycles
`timescale 1ns/1ps

module prng_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  // Half of the 40 ns period
  localparam int half_period = 20;
  // Reset length in clock cycles
  localparam int reset_cycles = 5;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(half_period);
      clk_o = ~clk_o;
    end
  end

  // Release lands 5 ns after a rising edge away from both sampling points
  initial begin
    rst_no = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    #5;
    rst_no = 1'b1;
  end

endmodule

//--- dv/tb_clearing_prng.sv
// Testbench top for the clearing PRNG; replays dv/clearing_prng_stim.txt against the DUT
`timescale 1ns/1ps

module tb_clearing_prng;
  import prng_pkg::*;

  // Upper bound for every wait loop, in clock cycles
  localparam int timeout_cycles = 200;
  // Idle cycles after each stimulus line
  localparam int idle_gap = 3;

  logic          clk;
  logic          rst_n;
  logic          data_req;
  logic          data_ack;
  prng_word_t    data0;
  prng_word_t    data1;
  logic          reseed_req;
  logic          reseed_ack;
  logic          entropy_req;
  logic          entropy_ack;
  entropy_word_t entropy;
  logic          exp_en;
  prng_word_t    exp_data0;
  int            test_id;
  logic [7:0]    test_kind;
  logic          test_end;
  logic          report;
  int            error_count;
  bit            run_failed;
  int            fd;

  prng_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  clearing_prng u_clearing_prng (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .data_req_i    (data_req),
    .data_ack_o    (data_ack),
    .data0_o       (data0),
    .data1_o       (data1),
    .reseed_req_i  (reseed_req),
    .reseed_ack_o  (reseed_ack),
    .entropy_req_o (entropy_req),
    .entropy_ack_i (entropy_ack),
    .entropy_i     (entropy)
  );

  prng_checker u_checker (
    .clk_i (clk), .rst_ni (rst_n),
    .data_req_i (data_req), .data_ack_i (data_ack), .data0_i (data0), .data1_i (data1),
    .reseed_req_i (reseed_req), .reseed_ack_i (reseed_ack),
    .entropy_req_i (entropy_req), .entropy_ack_i (entropy_ack), .entropy_i (entropy),
    .exp_en_i (exp_en), .exp_data0_i (exp_data0),
    .test_id_i (test_id), .test_kind_i (test_kind), .test_end_i (test_end),
    .report_i (report), .error_count_o (error_count)
  );

  // Inputs change 5 ns after the rising edge
  task automatic to_drive_point();
    @(posedge clk);
    #5;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset still active after %0d cycles", timeout_cycles);
      run_failed = 1'b1;
    end
  endtask

  // Holds data_req high until count cycles were acknowledged and leaves it high
  task automatic hold_data(input int count, input logic chk, input prng_word_t expected);
    int acks;
    int cycles;
    acks      = 0;
    cycles    = 0;
    data_req  = 1'b1;
    exp_en    = chk;
    exp_data0 = expected;
    while (acks < count && cycles < timeout_cycles) begin
      @(negedge clk);
      if (data_ack) begin
        acks++;
      end
      cycles++;
      to_drive_point();
      // Only the first acknowledged output is compared with the file
      if (acks > 0) begin
        exp_en = 1'b0;
      end
    end
    exp_en = 1'b0;
    if (acks < count) begin
      $display("Timeout: only %0d of %0d data requests acknowledged", acks, count);
      run_failed = 1'b1;
    end
  endtask

  // Entropy source with random idle gaps ahead of each word
  task automatic run_reseed(input entropy_word_t hi, input entropy_word_t lo, input int max_gap);
    int unsigned gap;
    int          words;
    int          cycles;
    logic        req_seen;
    logic        done;
    words      = 0;
    cycles     = 0;
    req_seen   = 1'b0;
    done       = 1'b0;
    gap        = $urandom_range(max_gap, 0);
    reseed_req = 1'b1;
    while (!done && cycles < timeout_cycles) begin
      if (req_seen && gap == 0) begin
        entropy_ack = 1'b1;
        entropy     = (words == 0) ? hi : lo;
      end else begin
        entropy_ack = 1'b0;
        entropy     = $urandom;
        if (req_seen) begin
          gap--;
        end
      end
      @(negedge clk);
      cycles++;
      if (entropy_ack && entropy_req) begin
        words++;
        gap = $urandom_range(max_gap, 0);
      end
      done     = reseed_ack;
      req_seen = entropy_req;
      to_drive_point();
    end
    reseed_req  = 1'b0;
    entropy_ack = 1'b0;
    if (!done) begin
      $display("Timeout: no reseed_ack_o within %0d cycles", timeout_cycles);
      run_failed = 1'b1;
    end
  endtask

  // Reseed raised in the middle of a held data request
  task automatic run_data_reseed(input entropy_word_t hi, input entropy_word_t lo,
                                 input int count, input prng_word_t expected);
    hold_data(count / 2, 1'b0, '0);
    if (!run_failed) begin
      run_reseed(hi, lo, 2);
    end
    if (!run_failed) begin
      hold_data(count - count / 2, 1'b1, expected);
    end
    data_req = 1'b0;
  endtask

  task automatic skip_comment();
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  task automatic bad_line();
    $display("Malformed stimulus line for test %0d (kind %c)", test_id, test_kind);
    run_failed = 1'b1;
  endtask

  initial begin
    logic [7:0]    kind;
    entropy_word_t hi;
    entropy_word_t lo;
    prng_word_t    expected;
    int            num;
    int            chk;
    int            code;
    data_req    = 1'b0;
    reseed_req  = 1'b0;
    entropy_ack = 1'b0;
    entropy     = '0;
    exp_en      = 1'b0;
    exp_data0   = '0;
    test_id     = 0;
    test_kind   = " ";
    test_end    = 1'b0;
    report      = 1'b0;
    run_failed  = 1'b0;
    void'($urandom(74211));
    fd = $fopen("dv/clearing_prng_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file dv/clearing_prng_stim.txt");
      run_failed = 1'b1;
    end else begin
      wait_reset_release();
      to_drive_point();
      while (!run_failed && !$feof(fd)) begin
        code = $fscanf(fd, " %c", kind);
        if (code != 1) begin
          break;
        end
        if (kind == "#") begin
          skip_comment();
        end else begin
          test_id++;
          test_kind = kind;
          case (kind)
            "R": begin
              code = $fscanf(fd, "%h %h %d", hi, lo, num);
              if (code == 3) run_reseed(hi, lo, num);
              else bad_line();
            end
            "D": begin
              code = $fscanf(fd, "%d %d %h", num, chk, expected);
              if (code == 3) hold_data(num, chk[0], expected);
              else bad_line();
              data_req = 1'b0;
            end
            "X": begin
              code = $fscanf(fd, "%h %h %d %h", hi, lo, num, expected);
              if (code == 4) run_data_reseed(hi, lo, num, expected);
              else bad_line();
            end
            "I": begin
              code = $fscanf(fd, "%d", num);
              if (code == 1) repeat (num) to_drive_point();
              else bad_line();
            end
            default: bad_line();
          endcase
          repeat (idle_gap) to_drive_point();
          test_end = 1'b1;
          to_drive_point();
          test_end = 1'b0;
        end
      end
      $fclose(fd);
    end
    report = 1'b1;
    @(negedge clk);
    #1;
    if (run_failed || error_count != 0) begin
      $display("Errors found");
    end else begin
      $display("No errors");
    end
    $finish;
  end

endmodule

//--- logic/clearing_prng.sv
// Top level of the clearing PRNG; joins the reseed collector and the LFSR core behind plain ports
`timescale 1ns/1ps

module clearing_prng (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Data port
  // Shares are valid in the cycle of the ack
  input  logic                    data_req_i,
  output logic                    data_ack_o,
  output prng_pkg::prng_word_t    data0_o,
  output prng_pkg::prng_word_t    data1_o,

  // Reseed port
  input  logic                    reseed_req_i,
  output logic                    reseed_ack_o,

  // Entropy port
  output logic                    entropy_req_o,
  input  logic                    entropy_ack_i,
  input  prng_pkg::entropy_word_t entropy_i
);
  import prng_pkg::*;

  logic       lfsr_en;
  logic       seed_en;
  prng_word_t seed;

  // LFSR advances once per acknowledged data cycle
  assign lfsr_en = data_req_i & data_ack_o;

  // Arbitration and seed packing
  prng_reseed_collector u_reseed (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_i),
    .data_ack_o    (data_ack_o),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i),
    .seed_en_o     (seed_en),
    .seed_o        (seed)
  );

  // State, non-linear output and share 1
  prng_lfsr_core u_lfsr (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .lfsr_en_i (lfsr_en),
    .seed_en_i (seed_en),
    .seed_i    (seed),
    .data0_o   (data0_o),
    .data1_o   (data1_o)
  );

endmodule

//--- logic/prng_lfsr_core.sv
// LFSR core of the clearing PRNG; steps on data acks, loads seeds and forms both output shares
`timescale 1ns/1ps
`include "prng_settings.svh"

module prng_lfsr_core (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Step and seed controls
  input  logic                 lfsr_en_i,
  input  logic                 seed_en_i,
  input  prng_pkg::prng_word_t seed_i,

  // Output shares
  output prng_pkg::prng_word_t data0_o,
  output prng_pkg::prng_word_t data1_o
);
  import prng_pkg::*;

  prng_word_t state_q;
  prng_word_t state_d;
  prng_word_t lfsr_step;
  prng_word_t fb_mask;

  // Feedback is applied only when the dropped bit is set
  assign fb_mask = {`PRNG_WIDTH{state_q[0]}} & `PRNG_LFSR_TAPS;

  // Galois XOR step, shifting towards bit 0
  assign lfsr_step = (state_q >> 1) ^ fb_mask;

  // Seeding has priority over stepping
  always_comb begin
    if (seed_en_i) begin
      state_d = seed_i;
    end else if (lfsr_en_i) begin
      state_d = lfsr_step;
    end else begin
      state_d = state_q;
    end
  end

  // State register
  // Reset value is a fixed nonzero seed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= `PRNG_DEFAULT_SEED;
    end else begin
      state_q <= state_d;
    end
  end

  // Share 0 from the permuted state through the S-box layer
  assign data0_o = nonlinear_out(state_q);

  // Share 1 is a fixed rewiring of share 0
  assign data1_o = share_perm(data0_o);

  // Both permutations must hit every bit once
  // A one-hot sweep ORs up to all ones only for a bijection
  initial begin : p_perm_check
    prng_word_t state_cover;
    prng_word_t share_cover;
    prng_word_t one_hot;
    state_cover = '0;
    share_cover = '0;
    for (int i = 0; i < `PRNG_WIDTH; i++) begin
      one_hot     = prng_word_t'(1) << i;
      state_cover = state_cover | state_perm(one_hot);
      share_cover = share_cover | share_perm(one_hot);
    end
    assert (&state_cover)
      else $error("state permutation is not bijective");
    assert (&share_cover)
      else $error("share permutation is not bijective");
  end

  // An all-zero state would lock the LFSR for good
  // Reached only through a zero seed from the entropy port
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q != '0)
    else $error("LFSR state is all zeros");

endmodule

//--- logic/prng_pkg.sv
// Types and word functions of the clearing PRNG, shared by the RTL and the testbench model
`include "prng_settings.svh"

package prng_pkg;

  // One LFSR state or one output share
  typedef logic [`PRNG_WIDTH-1:0] prng_word_t;

  // One word from the entropy port
  typedef logic [`PRNG_ENTROPY_WIDTH-1:0] entropy_word_t;

  // Reseed collector states
  // RS_WAIT_HIGH waits for the first word, RS_WAIT_LOW for the second
  typedef enum logic [1:0] {
    RS_IDLE      = 2'd0,
    RS_WAIT_LOW  = 2'd1,
    RS_WAIT_HIGH = 2'd2
  } reseed_state_e;

  // PRINCE 4-bit S-box
  localparam logic [3:0] prince_sbox [16] = '{
    4'hB, 4'hF, 4'h3, 4'h2, 4'hA, 4'hC, 4'h9, 4'h1,
    4'h6, 4'h7, 4'h8, 4'h0, 4'hE, 4'h5, 4'hD, 4'h4
  };

  // Affine bit permutation
  // Output bit i is input bit (mul * i + add) mod width
  function automatic prng_word_t bit_perm(input prng_word_t  x,
                                          input int unsigned mul,
                                          input int unsigned add);
    prng_word_t y;
    y = '0;
    for (int unsigned i = 0; i < `PRNG_WIDTH; i++) begin
      y[i] = x[(mul * i + add) % `PRNG_WIDTH];
    end
    return y;
  endfunction

  // Permutation applied to the LFSR state ahead of the S-boxes
  function automatic prng_word_t state_perm(input prng_word_t x);
    return bit_perm(x, `PRNG_STATE_PERM_MUL, 0);
  endfunction

  // Permutation that derives share 1 from share 0
  function automatic prng_word_t share_perm(input prng_word_t x);
    return bit_perm(x, `PRNG_SHARE_PERM_MUL, `PRNG_SHARE_PERM_ADD);
  endfunction

  // Share 0 output
  // Permute the state, then substitute every nibble
  function automatic prng_word_t nonlinear_out(input prng_word_t state);
    prng_word_t p;
    prng_word_t y;
    p = state_perm(state);
    for (int n = 0; n < `PRNG_WIDTH / 4; n++) begin
      y[4*n +: 4] = prince_sbox[p[4*n +: 4]];
    end
    return y;
  endfunction

endpackage

//--- logic/prng_reseed_collector.sv
// Reseed arbiter of the clearing PRNG; gates data acks and packs two entropy words into a seed
`timescale 1ns/1ps

module prng_reseed_collector (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Consumer side
  input  logic                    data_req_i,
  output logic                    data_ack_o,
  input  logic                    reseed_req_i,
  output logic                    reseed_ack_o,

  // Entropy source
  output logic                    entropy_req_o,
  input  logic                    entropy_ack_i,
  input  prng_pkg::entropy_word_t entropy_i,

  // Seed towards the LFSR core
  output logic                    seed_en_o,
  output prng_pkg::prng_word_t    seed_o
);
  import prng_pkg::*;

  reseed_state_e state_q;
  reseed_state_e state_d;
  entropy_word_t buffer_q;
  logic          word_taken;
  logic          high_word;

  // Reseed wins over data, so data acks stall while a reseed is pending
  assign data_ack_o = reseed_req_i ? 1'b0 : data_req_i;

  // Entropy is requested for as long as the consumer asks for a reseed
  // The consumer drops its request after the ack, which ends the entropy request too
  assign entropy_req_o = reseed_req_i;

  // Handshake on the entropy port
  assign word_taken = entropy_req_o & entropy_ack_i;

  // First word of a reseed goes to the high half
  assign high_word = word_taken & (state_q != RS_WAIT_LOW);

  // Second word completes the seed in the same cycle
  assign seed_en_o    = word_taken & (state_q == RS_WAIT_LOW);
  assign reseed_ack_o = seed_en_o;

  // Buffered high word joined with the live low word
  assign seed_o = {buffer_q, entropy_i};

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RS_IDLE: begin
        // First accepted word moves on to the low half
        if (high_word) begin
          state_d = RS_WAIT_LOW;
        end
      end
      RS_WAIT_LOW: begin
        // Seed loads at this edge
        if (seed_en_o || !reseed_req_i) begin
          state_d = RS_IDLE;
        end
      end
      default: begin
        state_d = RS_IDLE;
      end
    endcase
  end

  // State register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // High word buffer
  always_ff @(posedge clk_i) begin
    if (high_word) begin
      buffer_q <= entropy_i;
    end
  end

  // The consumer keeps asking until the seed is complete
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    reseed_req_i && !reseed_ack_o |=> reseed_req_i)
    else $error("reseed_req_i dropped before reseed_ack_o");

  // No further entropy is requested once the seed has loaded
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    reseed_ack_o |=> !entropy_req_o)
    else $error("entropy_req_o still high after reseed_ack_o");

endmodule

//--- logic/prng_settings.svh
// Shared constants for the clearing PRNG, included by the package and the LFSR core
`ifndef PRNG_SETTINGS_SVH
`define PRNG_SETTINGS_SVH

// Width of the LFSR state and of each output share
`define PRNG_WIDTH 64

// Width of one word on the entropy port
`define PRNG_ENTROPY_WIDTH 32

// LFSR state right after reset
`define PRNG_DEFAULT_SEED 64'h3B9A_C5D1_7E42_86F0

// Galois feedback mask for x^64 + x^4 + x^3 + x + 1
// Bit b stands for the x^(b+1) term and the constant term is implicit
`define PRNG_LFSR_TAPS 64'h8000_0000_0000_000D

// Output bit i takes input bit (mul * i + add) mod 64
// Odd multipliers keep both mappings bijective
`define PRNG_STATE_PERM_MUL 5
`define PRNG_SHARE_PERM_MUL 13
`define PRNG_SHARE_PERM_ADD 7

`endif
